// File: logic/exec_pkg.sv
// ==========================================================
// Execute unit shared definitions
// Data word, opcode and fault code types
// Opcode values for the integer and capability groups
// Fault codes and the controller state enum
// ==========================================================

package exec_pkg;

	// Operand and result word
	typedef logic [127:0] data_t;
	typedef logic [5:0]   opcode_t;
	typedef logic [3:0]   fault_t;

	// Top opcode bit selects the capability group
	localparam int OP_CLASS_BIT = 5;

	// ==========================================================
	// Integer group
	// ==========================================================
	localparam opcode_t OP_ADD  = 6'h00;
	localparam opcode_t OP_ADDI = 6'h01;
	localparam opcode_t OP_ABS  = 6'h02;
	localparam opcode_t OP_SUBF = 6'h03;
	localparam opcode_t OP_MOV  = 6'h04;
	localparam opcode_t OP_AND  = 6'h08;
	localparam opcode_t OP_NAND = 6'h09;
	localparam opcode_t OP_ANDN = 6'h0A;
	localparam opcode_t OP_OR   = 6'h0C;
	localparam opcode_t OP_NOR  = 6'h0D;
	localparam opcode_t OP_ORN  = 6'h0E;
	localparam opcode_t OP_XOR  = 6'h10;
	localparam opcode_t OP_XNOR = 6'h11;
	localparam opcode_t OP_XORN = 6'h12;

	// ==========================================================
	// Capability group, all with bit 5 set
	// ==========================================================
	localparam opcode_t OP_CGETBASE   = 6'h20;
	localparam opcode_t OP_CGETTOP    = 6'h21;
	localparam opcode_t OP_CGETLEN    = 6'h22;
	localparam opcode_t OP_CGETPERMS  = 6'h23;
	localparam opcode_t OP_CANDPERMS  = 6'h28;
	localparam opcode_t OP_CSEALENTRY = 6'h29;
	localparam opcode_t OP_CLOADCHK   = 6'h2A;

	// Fault codes returned on exc
	localparam fault_t FLT_NONE      = 4'd0;
	localparam fault_t FLT_UNIMP     = 4'd1;
	localparam fault_t FLT_CAPTAG    = 4'd2;
	localparam fault_t FLT_CAPSEALED = 4'd3;
	localparam fault_t FLT_CAPPERMS  = 4'd4;
	localparam fault_t FLT_CAPBOUNDS = 4'd5;

	// Slave controller states
	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_ack
	} exec_state_t;

endpackage

// File: logic/cap_pkg.sv
// ==========================================================
// Capability format definitions
// Field types and bit layout of the 128-bit capability
// Object type constants and permission bit numbers
// ==========================================================

package cap_pkg;

	typedef logic [63:0] addr_t;
	// Base and top need one bit above the address
	typedef logic [64:0] bound_t;
	typedef logic [15:0] perms_t;
	typedef logic [17:0] otype_t;
	typedef logic [5:0]  exp_t;
	typedef logic [9:0]  mant_t;

	// ==========================================================
	// Field widths and low bit positions
	// ==========================================================
	localparam int ADDR_W  = 64;
	localparam int PERMS_W = 16;
	localparam int OTYPE_W = 18;
	localparam int FLAGS_W = 4;
	localparam int EXP_W   = 6;
	localparam int MANT_W  = 10;

	localparam int ADDR_LSB   = 0;
	localparam int PERMS_LSB  = ADDR_LSB + ADDR_W;
	localparam int OTYPE_LSB  = PERMS_LSB + PERMS_W;
	localparam int FLAGS_LSB  = OTYPE_LSB + OTYPE_W;
	localparam int EXP_LSB    = FLAGS_LSB + FLAGS_W;
	localparam int BFIELD_LSB = EXP_LSB + EXP_W;
	localparam int TFIELD_LSB = BFIELD_LSB + MANT_W;

	// Larger exponents behave as this one
	localparam exp_t E_MAX = 6'd54;

	// Object types, anything below the sentry value is sealed
	localparam otype_t OTYPE_UNSEALED = 18'h3FFFF;
	localparam otype_t OTYPE_SENTRY   = 18'h3FFFE;

	// Permission bit numbers
	localparam int PERMIT_LOAD     = 1;
	localparam int PERMIT_LOAD_CAP = 3;

	// Access size covered by the load check, in bytes
	localparam int LOAD_SIZE = 8;

endpackage

// File: logic/op_bus_if.sv
// ==========================================================
// Operation bus
// Captured opcode and operands from the controller
// to the integer ALU and the capability unit
// ==========================================================

`timescale 1ns/1ps

interface op_bus_if import exec_pkg::*; ();

	// One-cycle pulse when a new operation is captured
	logic    valid;
	opcode_t op;
	data_t   a;
	data_t   b;
	data_t   imm;
	// Tag bits of the two operands
	logic    a_tag;
	logic    b_tag;

	// Controller side
	modport ctrl (
		output valid, op, a, b, imm, a_tag, b_tag
	);

	// Functional unit side
	modport unit (
		input valid, op, a, b, imm, a_tag, b_tag
	);

endinterface

// File: logic/int_alu.sv
// ==========================================================
// Integer ALU
// Add, add immediate, absolute sum, subtract from, move
// And, or, xor with their inverted forms
// Flags any opcode outside the group as unimplemented
// ==========================================================

`timescale 1ns/1ps

module int_alu import exec_pkg::*; (
	op_bus_if.unit bus,
	output data_t  result,
	output logic   unimp
);

	// Sum shared by ADD and ABS
	data_t sum_ab;
	data_t neg_sum;

	assign sum_ab = bus.a + bus.b;
	assign neg_sum = -sum_ab;

	always_comb begin
		result = '0;
		unimp = 1'b0;
		case (bus.op)
			// Arithmetic, all wraps at 128 bits
			OP_ADD:
				result = sum_ab;
			OP_ADDI:
				result = bus.a + bus.imm;
			OP_ABS:
				// Sign bit of the sum picks the negated value
				result = sum_ab[127] ? neg_sum : sum_ab;
			OP_SUBF:
				result = bus.b - bus.a;
			OP_MOV:
				result = bus.a;

			// And family
			OP_AND:
				result = bus.a & bus.b;
			OP_NAND:
				result = ~(bus.a & bus.b);
			OP_ANDN:
				result = bus.a & ~bus.b;

			// Or family
			OP_OR:
				result = bus.a | bus.b;
			OP_NOR:
				result = ~(bus.a | bus.b);
			OP_ORN:
				result = bus.a | ~bus.b;

			// Xor family
			OP_XOR:
				result = bus.a ^ bus.b;
			OP_XNOR:
				result = ~(bus.a ^ bus.b);
			OP_XORN:
				result = bus.a ^ ~bus.b;

			// Not an integer opcode
			default: begin
				result = '0;
				unimp = 1'b1;
			end
		endcase
	end

endmodule

// File: logic/cap_bounds.sv
// ==========================================================
// Capability bounds decoder
// Base and top from the address, exponent and B/T fields
// Top wraps by one block when T is below B
// ==========================================================

`timescale 1ns/1ps

module cap_bounds import exec_pkg::*, cap_pkg::*; (
	input  data_t  cap,
	output bound_t base,
	output bound_t top
);

	// Raw fields
	addr_t addr;
	exp_t  e_raw;
	mant_t b_fld;
	mant_t t_fld;

	// Exponent after the limit
	exp_t       e_lim;
	// Number of low address bits covered by the mantissa
	logic [6:0] lo_bits;

	bound_t hi_mask;
	bound_t hi_part;
	bound_t b_shift;
	bound_t t_shift;
	bound_t t_wrap;

	assign addr  = cap[ADDR_LSB +: ADDR_W];
	assign e_raw = cap[EXP_LSB +: EXP_W];
	assign b_fld = cap[BFIELD_LSB +: MANT_W];
	assign t_fld = cap[TFIELD_LSB +: MANT_W];

	// Exponents above the limit act as the limit
	assign e_lim = (e_raw > E_MAX) ? E_MAX : e_raw;
	assign lo_bits = {1'b0, e_lim} + 7'(MANT_W);

	// Address with its low E+10 bits cleared
	assign hi_mask = {65{1'b1}} << lo_bits;
	assign hi_part = {1'b0, addr} & hi_mask;

	// Mantissas scaled by the exponent
	assign b_shift = bound_t'(b_fld) << e_lim;
	assign t_shift = bound_t'(t_fld) << e_lim;

	// Top lies in the next block when T is below B
	assign t_wrap = (t_fld < b_fld) ? (bound_t'(1) << lo_bits) : '0;

	assign base = hi_part + b_shift;
	assign top  = hi_part + t_shift + t_wrap;

endmodule

// File: logic/cap_unit.sv
// ==========================================================
// Capability unit
// Stage 1 registers decoded bounds of a and the operands
// Stage 2 builds the result, tag and fault code
// Get base, top, length, perms, and-perms, seal-entry
// and the load permission check
// ==========================================================

`timescale 1ns/1ps

module cap_unit import exec_pkg::*, cap_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	op_bus_if.unit bus,
	output logic   done,
	output data_t  result,
	output logic   tag,
	output fault_t fault
);

	// Combinational bounds of the incoming a operand
	bound_t dec_base;
	bound_t dec_top;

	// Stage 1 register
	opcode_t s1_op;
	data_t   s1_a;
	data_t   s1_b;
	logic    s1_a_tag;
	bound_t  s1_base;
	bound_t  s1_top;

	// Fields of the registered a operand
	addr_t  a_addr;
	perms_t a_perms;
	otype_t a_otype;
	logic   a_unsealed;
	bound_t acc_end;

	cap_bounds u_bounds (
		.cap  (bus.a),
		.base (dec_base),
		.top  (dec_top)
	);

	// ==========================================================
	// Stage 1
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= bus.valid;
		end
	end

	// Operand and bounds payload, loaded on each new operation
	always_ff @(posedge clk) begin
		if (bus.valid) begin
			s1_op    <= bus.op;
			s1_a     <= bus.a;
			s1_b     <= bus.b;
			s1_a_tag <= bus.a_tag;
			s1_base  <= dec_base;
			s1_top   <= dec_top;
		end
	end

	// ==========================================================
	// Stage 2
	// ==========================================================
	assign a_addr     = s1_a[ADDR_LSB +: ADDR_W];
	assign a_perms    = s1_a[PERMS_LSB +: PERMS_W];
	assign a_otype    = s1_a[OTYPE_LSB +: OTYPE_W];
	assign a_unsealed = (a_otype == OTYPE_UNSEALED);
	// End of the load access, one past the last byte
	assign acc_end    = {1'b0, a_addr} + bound_t'(LOAD_SIZE);

	always_comb begin
		result = '0;
		tag = 1'b0;
		fault = FLT_NONE;
		case (s1_op)
			// Bounds and perms reads come back untagged
			OP_CGETBASE:
				result = data_t'(s1_base);
			OP_CGETTOP:
				result = data_t'(s1_top);
			OP_CGETLEN:
				result = data_t'(s1_top - s1_base);
			OP_CGETPERMS:
				result = data_t'(a_perms);
			OP_CANDPERMS: begin
				result = s1_a;
				result[PERMS_LSB +: PERMS_W] = a_perms & s1_b[PERMS_W-1:0];
				// Sealed and sentry inputs lose the tag
				tag = s1_a_tag & a_unsealed;
			end
			OP_CSEALENTRY: begin
				result = s1_a;
				if (a_unsealed) begin
					result[OTYPE_LSB +: OTYPE_W] = OTYPE_SENTRY;
					tag = s1_a_tag;
				end
			end
			OP_CLOADCHK: begin
				result = s1_a;
				tag = s1_a_tag;
				// First failing check wins
				if (!s1_a_tag)
					fault = FLT_CAPTAG;
				else if (!a_unsealed)
					fault = FLT_CAPSEALED;
				else if (!a_perms[PERMIT_LOAD] || !a_perms[PERMIT_LOAD_CAP])
					fault = FLT_CAPPERMS;
				else if ({1'b0, a_addr} < s1_base || acc_end > s1_top)
					fault = FLT_CAPBOUNDS;
				else
					fault = FLT_NONE;
			end
			// Unknown opcode in the capability space
			default:
				fault = FLT_UNIMP;
		endcase
	end

endmodule

// File: logic/exec_unit.sv
// ==========================================================
// Execute unit top level
// Wishbone classic slave controller with cyc, stb and ack
// Operand capture onto the operation bus
// Integer ALU and capability unit with result select
// ==========================================================

`timescale 1ns/1ps

module exec_unit import exec_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    cyc,
	input  logic    stb,
	input  opcode_t op,
	input  data_t   dat_a,
	input  data_t   dat_b,
	input  data_t   imm,
	input  logic    a_tag,
	input  logic    b_tag,
	output logic    ack,
	output logic    tag_o,
	output data_t   dat_o,
	output fault_t  exc
);

	exec_state_t state;

	// Integer ALU answer
	data_t  alu_result;
	logic   alu_unimp;

	// Capability unit answer
	logic   cap_done;
	data_t  cap_result;
	logic   cap_tag;
	fault_t cap_fault;

	// Capability class selected by the top opcode bit
	logic   cap_sel;

	op_bus_if op_bus ();

	int_alu u_int_alu (
		.bus    (op_bus),
		.result (alu_result),
		.unimp  (alu_unimp)
	);

	cap_unit u_cap_unit (
		.clk    (clk),
		.rst    (rst),
		.bus    (op_bus),
		.done   (cap_done),
		.result (cap_result),
		.tag    (cap_tag),
		.fault  (cap_fault)
	);

	assign cap_sel = op_bus.op[OP_CLASS_BIT];

	// ==========================================================
	// Operand capture
	// ==========================================================
	// New request is taken only from idle
	always_ff @(posedge clk) begin
		if (state == st_idle && cyc && stb) begin
			op_bus.op    <= op;
			op_bus.a     <= dat_a;
			op_bus.b     <= dat_b;
			op_bus.imm   <= imm;
			op_bus.a_tag <= a_tag;
			op_bus.b_tag <= b_tag;
		end
	end

	// ==========================================================
	// Slave controller
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= st_idle;
			op_bus.valid <= 1'b0;
			ack          <= 1'b0;
			tag_o        <= 1'b0;
			dat_o        <= '0;
			exc          <= FLT_NONE;
		end else begin
			op_bus.valid <= 1'b0;
			case (state)
				st_idle:
					if (cyc && stb) begin
						op_bus.valid <= 1'b1;
						state <= st_busy;
					end
				st_busy:
					// Integer results are ready one edge after capture
					if (!cap_sel) begin
						dat_o <= alu_result;
						tag_o <= 1'b0;
						exc   <= alu_unimp ? FLT_UNIMP : FLT_NONE;
						ack   <= 1'b1;
						state <= st_ack;
					end else if (cap_done) begin
						dat_o <= cap_result;
						tag_o <= cap_tag;
						exc   <= cap_fault;
						ack   <= 1'b1;
						state <= st_ack;
					end
				st_ack: begin
					// Single-cycle ack, stb is still high here
					ack   <= 1'b0;
					state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

// File: tb/exec_unit_tb.sv
// ==========================================================
// Execute unit testbench
// Table of operations with expected result, tag and fault
// Reference model for the integer and capability rules
// Ack latency checks, cycle counter timeout
// ==========================================================

`timescale 1ns/1ps

module exec_unit_tb import exec_pkg::*, cap_pkg::*; ();

	localparam int MAX_ENTRIES = 96;

	logic    clk = 1'b0;
	logic    rst;
	logic    cyc;
	logic    stb;
	opcode_t op;
	data_t   dat_a;
	data_t   dat_b;
	data_t   imm;
	logic    a_tag;
	logic    b_tag;
	logic    ack;
	logic    tag_o;
	data_t   dat_o;
	fault_t  exc;

	// Stimulus and expected values, one row per operation
	opcode_t t_op [MAX_ENTRIES];
	data_t   t_a [MAX_ENTRIES];
	data_t   t_b [MAX_ENTRIES];
	data_t   t_imm [MAX_ENTRIES];
	logic    t_a_tag [MAX_ENTRIES];
	logic    t_b_tag [MAX_ENTRIES];
	data_t   t_res [MAX_ENTRIES];
	logic    t_tag [MAX_ENTRIES];
	fault_t  t_flt [MAX_ENTRIES];
	int      n_entries = 0;

	integer  seed = 32'hae8c;
	int      n_errors = 0;
	int      n_checks = 0;
	int      cycle_cnt = 0;
	int      timeout_cycles = 0;

	exec_unit uut (
		.clk   (clk),
		.rst   (rst),
		.cyc   (cyc),
		.stb   (stb),
		.op    (op),
		.dat_a (dat_a),
		.dat_b (dat_b),
		.imm   (imm),
		.a_tag (a_tag),
		.b_tag (b_tag),
		.ack   (ack),
		.tag_o (tag_o),
		.dat_o (dat_o),
		.exc   (exc)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	// Run limit from the table length
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (timeout_cycles != 0 && cycle_cnt >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_cnt);
			$display("Checks: %0d, errors: %0d", n_checks, n_errors);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Capability word from its fields, flags left zero
	function automatic data_t make_cap(input mant_t t, input mant_t b, input exp_t e,
			input otype_t ot, input perms_t p, input addr_t ad);
		return {t, b, e, 4'h0, ot, p, ad};
	endfunction

	task automatic rand_word(output data_t w);
		for (int k = 0; k < 4; k++)
			w[k*32 +: 32] = $random(seed);
	endtask

	// Bounds from the compressed fields, block arithmetic on 65 bits
	task automatic find_bounds(input data_t cap, output bound_t base, output bound_t top);
		int     e;
		bound_t blk;
		bound_t ad;
		bound_t hi;
		mant_t  bf;
		mant_t  tf;
		e = int'(cap[EXP_LSB +: EXP_W]);
		if (e > int'(E_MAX))
			e = int'(E_MAX);
		bf = cap[BFIELD_LSB +: MANT_W];
		tf = cap[TFIELD_LSB +: MANT_W];
		blk = bound_t'(1) << (e + MANT_W);
		ad = {1'b0, cap[ADDR_LSB +: ADDR_W]};
		hi = ad - (ad % blk);
		base = hi + bound_t'(bf) * (bound_t'(1) << e);
		top = hi + bound_t'(tf) * (bound_t'(1) << e);
		if (tf < bf)
			top = top + blk;
	endtask

	// ==========================================================
	// Reference model
	// ==========================================================
	task automatic compute_expected(input opcode_t o, input data_t a, input data_t b,
			input data_t im, input logic at, output data_t res, output logic tag,
			output fault_t flt);
		data_t  sum;
		bound_t base;
		bound_t top;
		bound_t end_addr;
		perms_t p;
		otype_t ot;
		res = '0;
		tag = 1'b0;
		flt = FLT_NONE;
		sum = a + b;
		find_bounds(a, base, top);
		p = a[PERMS_LSB +: PERMS_W];
		ot = a[OTYPE_LSB +: OTYPE_W];
		end_addr = {1'b0, a[ADDR_LSB +: ADDR_W]} + bound_t'(LOAD_SIZE);
		case (o)
			OP_ADD:  res = sum;
			OP_ADDI: res = a + im;
			OP_ABS:  res = ($signed(sum) < 0) ? (~sum + 128'd1) : sum;
			OP_SUBF: res = b - a;
			OP_MOV:  res = a;
			OP_AND:  res = a & b;
			OP_NAND: res = ~(a & b);
			OP_ANDN: res = a & ~b;
			OP_OR:   res = a | b;
			OP_NOR:  res = ~(a | b);
			OP_ORN:  res = a | ~b;
			OP_XOR:  res = a ^ b;
			OP_XNOR: res = ~(a ^ b);
			OP_XORN: res = a ^ ~b;
			OP_CGETBASE:  res = data_t'(base);
			OP_CGETTOP:   res = data_t'(top);
			OP_CGETLEN:   res = data_t'(bound_t'(top - base));
			OP_CGETPERMS: res = data_t'(p);
			OP_CANDPERMS: begin
				res = a;
				res[PERMS_LSB +: PERMS_W] = p & b[PERMS_W-1:0];
				tag = at & (ot == OTYPE_UNSEALED);
			end
			OP_CSEALENTRY: begin
				res = a;
				if (ot == OTYPE_UNSEALED) begin
					res[OTYPE_LSB +: OTYPE_W] = OTYPE_SENTRY;
					tag = at;
				end
			end
			OP_CLOADCHK: begin
				res = a;
				tag = at;
				if (!at)
					flt = FLT_CAPTAG;
				else if (ot != OTYPE_UNSEALED)
					flt = FLT_CAPSEALED;
				else if (!p[PERMIT_LOAD] || !p[PERMIT_LOAD_CAP])
					flt = FLT_CAPPERMS;
				else if ({1'b0, a[ADDR_LSB +: ADDR_W]} < base || end_addr > top)
					flt = FLT_CAPBOUNDS;
			end
			default: flt = FLT_UNIMP;
		endcase
	endtask

	task automatic add_entry_exp(input opcode_t o, input data_t a, input data_t b,
			input data_t im, input logic at, input logic bt, input data_t res,
			input logic tag, input fault_t flt);
		if (n_entries >= MAX_ENTRIES) begin
			$display("Stimulus table is full, entry dropped");
			n_errors++;
		end else begin
			t_op[n_entries] = o;
			t_a[n_entries] = a;
			t_b[n_entries] = b;
			t_imm[n_entries] = im;
			t_a_tag[n_entries] = at;
			t_b_tag[n_entries] = bt;
			t_res[n_entries] = res;
			t_tag[n_entries] = tag;
			t_flt[n_entries] = flt;
			n_entries++;
		end
	endtask

	task automatic add_entry(input opcode_t o, input data_t a, input data_t b,
			input data_t im, input logic at, input logic bt);
		data_t  res;
		logic   tag;
		fault_t flt;
		compute_expected(o, a, b, im, at, res, tag, flt);
		add_entry_exp(o, a, b, im, at, bt, res, tag, flt);
	endtask

	// Ack must be low outside the single ack cycle
	task automatic check_ack_low(input int idx);
		n_checks++;
		if (ack !== 1'b0) begin
			$display("ERR entry %0d op %h: ack = %h after the ack cycle, expected %h",
				idx, t_op[idx], ack, 1'b0);
			n_errors++;
		end
	endtask

	// ==========================================================
	// Table contents
	// ==========================================================
	task automatic build_table();
		opcode_t int_ops [14];
		data_t   a;
		data_t   b;
		data_t   im;
		logic [31:0] r;
		data_t   cap_x;
		data_t   cap_y;
		data_t   cap_z;
		data_t   mask;
		otype_t  ots [3];
		int_ops = '{OP_ADD, OP_ADDI, OP_ABS, OP_SUBF, OP_MOV, OP_AND, OP_NAND,
			OP_ANDN, OP_OR, OP_NOR, OP_ORN, OP_XOR, OP_XNOR, OP_XORN};
		// Random integer operands, random input tags
		foreach (int_ops[k]) begin
			repeat (3) begin
				rand_word(a);
				rand_word(b);
				rand_word(im);
				r = $random(seed);
				add_entry(int_ops[k], a, b, im, r[0], r[1]);
			end
		end
		// Wrap and absolute value corners, hand values
		add_entry_exp(OP_ADD, '1, 128'd1, '0, 1'b1, 1'b1, '0, 1'b0, FLT_NONE);
		add_entry_exp(OP_ABS, -128'sd5, 128'd2, '0, 1'b0, 1'b0, 128'd3, 1'b0, FLT_NONE);
		add_entry(OP_ABS, {1'b1, 127'd0}, '0, '0, 1'b0, 1'b0);
		// Unknown opcodes in both halves
		add_entry(6'h1F, '1, '1, '0, 1'b1, 1'b0);
		add_entry(6'h3F, '1, '1, '0, 1'b1, 1'b0);

		// T below B: block 2^14, base 0x123000, top 0x125000
		cap_x = make_cap(10'h100, 10'h300, 6'd4, OTYPE_UNSEALED, 16'hFFFF, 64'h123456);
		add_entry_exp(OP_CGETBASE, cap_x, '0, '0, 1'b1, 1'b0, 128'h123000, 1'b0, FLT_NONE);
		add_entry_exp(OP_CGETTOP, cap_x, '0, '0, 1'b1, 1'b0, 128'h125000, 1'b0, FLT_NONE);
		add_entry_exp(OP_CGETLEN, cap_x, '0, '0, 1'b1, 1'b0, 128'h2000, 1'b0, FLT_NONE);
		// E of 63 acts as 54, top carries into bit 64
		cap_y = make_cap(10'h100, 10'h200, 6'd63, OTYPE_UNSEALED, 16'hFFFF,
			64'hDEAD_BEEF_0000_1234);
		add_entry_exp(OP_CGETBASE, cap_y, '0, '0, 1'b1, 1'b0,
			128'h0_8000_0000_0000_0000, 1'b0, FLT_NONE);
		add_entry_exp(OP_CGETTOP, cap_y, '0, '0, 1'b1, 1'b0,
			128'h1_4000_0000_0000_0000, 1'b0, FLT_NONE);
		add_entry_exp(OP_CGETLEN, cap_y, '0, '0, 1'b1, 1'b0,
			128'h0_C000_0000_0000_0000, 1'b0, FLT_NONE);
		// Plain case, base 0x1010 and top 0x1100
		cap_z = make_cap(10'h100, 10'h010, 6'd0, OTYPE_UNSEALED, 16'h00FF, 64'h1050);
		add_entry(OP_CGETBASE, cap_z, '0, '0, 1'b1, 1'b0);
		add_entry(OP_CGETTOP, cap_z, '0, '0, 1'b1, 1'b0);
		add_entry(OP_CGETLEN, cap_z, '0, '0, 1'b1, 1'b0);
		add_entry(OP_CGETPERMS, cap_z, '0, '0, 1'b1, 1'b0);

		// Unsealed, sentry and sealed inputs
		ots = '{OTYPE_UNSEALED, OTYPE_SENTRY, 18'h00005};
		rand_word(mask);
		foreach (ots[k]) begin
			a = make_cap(10'h100, 10'h010, 6'd0, ots[k], 16'hA5C3, 64'h1050);
			add_entry(OP_CANDPERMS, a, mask, '0, 1'b1, 1'b0);
			add_entry(OP_CSEALENTRY, a, '0, '0, 1'b1, 1'b0);
		end

		// Load check faults in priority order
		a = make_cap(10'h100, 10'h010, 6'd0, 18'h00005, 16'h0000, 64'h1050);
		add_entry(OP_CLOADCHK, a, '0, '0, 1'b0, 1'b0);
		add_entry(OP_CLOADCHK, a, '0, '0, 1'b1, 1'b0);
		a = make_cap(10'h100, 10'h010, 6'd0, OTYPE_UNSEALED, 16'h0002, 64'h2000);
		add_entry(OP_CLOADCHK, a, '0, '0, 1'b1, 1'b0);
		a = make_cap(10'h100, 10'h010, 6'd0, OTYPE_UNSEALED, 16'h000A, 64'h1008);
		add_entry(OP_CLOADCHK, a, '0, '0, 1'b1, 1'b0);
		a[ADDR_LSB +: ADDR_W] = 64'h10F9;
		add_entry(OP_CLOADCHK, a, '0, '0, 1'b1, 1'b0);
		// Ends exactly at top
		a[ADDR_LSB +: ADDR_W] = 64'h10F8;
		add_entry_exp(OP_CLOADCHK, a, '0, '0, 1'b1, 1'b0, a, 1'b1, FLT_NONE);
		a[ADDR_LSB +: ADDR_W] = 64'h1050;
		add_entry(OP_CLOADCHK, a, '0, '0, 1'b1, 1'b0);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial begin
		int lat;
		int exp_lat;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		op = '0;
		dat_a = '0;
		dat_b = '0;
		imm = '0;
		a_tag = 1'b0;
		b_tag = 1'b0;
		build_table();
		timeout_cycles = n_entries * 10 + 50;

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		n_checks += 4;
		if (ack !== 1'b0) begin
			$display("ERR after reset: ack = %h, expected %h", ack, 1'b0);
			n_errors++;
		end
		if (tag_o !== 1'b0) begin
			$display("ERR after reset: tag_o = %h, expected %h", tag_o, 1'b0);
			n_errors++;
		end
		if (dat_o !== '0) begin
			$display("ERR after reset: dat_o = %h, expected %h", dat_o, 128'd0);
			n_errors++;
		end
		if (exc !== FLT_NONE) begin
			$display("ERR after reset: exc = %h, expected %h", exc, FLT_NONE);
			n_errors++;
		end

		for (int i = 0; i < n_entries; i++) begin
			@(negedge clk);
			cyc = 1'b1;
			stb = 1'b1;
			op = t_op[i];
			dat_a = t_a[i];
			dat_b = t_b[i];
			imm = t_imm[i];
			a_tag = t_a_tag[i];
			b_tag = t_b_tag[i];
			// Count edges from the sampling edge until ack is seen
			lat = 0;
			do begin
				@(negedge clk);
				lat++;
			end while (ack !== 1'b1);
			exp_lat = t_op[i][OP_CLASS_BIT] ? 3 : 2;
			n_checks += 4;
			if (dat_o !== t_res[i]) begin
				$display("ERR entry %0d op %h: dat_o = %h, expected %h",
					i, t_op[i], dat_o, t_res[i]);
				n_errors++;
			end
			if (tag_o !== t_tag[i]) begin
				$display("ERR entry %0d op %h: tag_o = %h, expected %h",
					i, t_op[i], tag_o, t_tag[i]);
				n_errors++;
			end
			if (exc !== t_flt[i]) begin
				$display("ERR entry %0d op %h: exc = %h, expected %h",
					i, t_op[i], exc, t_flt[i]);
				n_errors++;
			end
			if (lat != exp_lat) begin
				$display("ERR entry %0d op %h: ack latency = %h, expected %h",
					i, t_op[i], lat, exp_lat);
				n_errors++;
			end
			// Stb stays high over the edge that ends ack, released in the cycle after
			@(negedge clk);
			cyc = 1'b0;
			stb = 1'b0;
			check_ack_low(i);
			@(negedge clk);
			check_ack_low(i);
		end

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: sources.f
logic/exec_pkg.sv
logic/cap_pkg.sv
logic/op_bus_if.sv
logic/int_alu.sv
logic/cap_bounds.sv
logic/cap_unit.sv
logic/exec_unit.sv
tb/exec_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = exec_unit_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "*** PASSED ***"

clean:
	rm -rf $(OBJ_DIR)
